/* common/fetch_macros.svh */
// size constants for the instruction fetch front end and its memory bus
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and instruction width
`define XLEN 32

// one memory word holds two instructions
`define BLOCK_BITS 64

// 32 direct-mapped lines
`define IDX_BITS 5

// tag bits above index and the 3 offset bits
// anything higher in the address must be zero
`define TAG_BITS 8

// memory transaction tag
`define MEM_TAG_BITS 4

// consumer buffer depth and its counter
`define FETCH_CREDITS 4
`define CREDIT_BITS 3

`endif

/* common/fetch_pkg.sv */
// shared types of the fetch front end for the memory bus, cache block and fetch packet
`default_nettype none
`include "fetch_macros.svh"

package fetch_pkg;

	// memory command, fetch only ever loads
	typedef enum logic [1:0] {
		mem_none = 2'h0,
		mem_load = 2'h1
	} mem_cmd_e;

	// one memory word, seen raw or as two instructions
	// inst[0] sits at the lower address
	typedef union packed {
		logic [`BLOCK_BITS-1:0] dword;
		logic [1:0][`XLEN-1:0] inst;
	} cache_block_u;

	// request toward memory
	typedef struct packed {
		mem_cmd_e cmd;
		logic [`XLEN-1:0] addr;
	} mem_req_t;

	// memory reply
	// response is the acceptance tag, zero when refused
	// tag names the transaction whose data is on the bus
	typedef struct packed {
		logic [`MEM_TAG_BITS-1:0] response;
		logic [`MEM_TAG_BITS-1:0] tag;
		cache_block_u data;
	} mem_rsp_t;

	// packet to the consumer
	// pc is the address of slot 0 of the block
	typedef struct packed {
		logic [1:0] valid;
		logic [`XLEN-1:0] pc;
		cache_block_u block;
	} fetch_packet_t;

	// write port from the miss controller into the cache arrays
	typedef struct packed {
		logic wr_en;
		logic [`IDX_BITS-1:0] idx;
		logic [`TAG_BITS-1:0] tag;
		cache_block_u data;
	} cache_fill_t;

endpackage

`default_nettype wire

/* icache/icache_mem.sv */
// direct-mapped instruction cache arrays with a combinational lookup and one fill port
`default_nettype none
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache_mem import fetch_pkg::*; (
	input  logic clock,
	input  logic rst,
	input  logic [`XLEN-1:0] lookup_pc,
	input  cache_fill_t cache_fill,
	output logic hit,
	output cache_block_u hit_block
);

	localparam int lines = 1 << `IDX_BITS;

	logic [lines-1:0] valid;
	logic [`TAG_BITS-1:0] tags [lines];
	cache_block_u data [lines];

	// lookup fields
	logic [`IDX_BITS-1:0] rd_idx;
	logic [`TAG_BITS-1:0] rd_tag;

	// offset bits 2:0 pick nothing here, whole block is read
	assign rd_idx = lookup_pc[`IDX_BITS+2:3];
	assign rd_tag = lookup_pc[`TAG_BITS+`IDX_BITS+2:`IDX_BITS+3];

	// read port
	assign hit = valid[rd_idx] && (tags[rd_idx] == rd_tag);
	assign hit_block = data[rd_idx];

	// valid bits, all cleared on reset
	always_ff @(posedge clock) begin
		if (rst) begin
			valid <= '0;
		end else if (cache_fill.wr_en) begin
			valid[cache_fill.idx] <= 1'b1;
		end
	end

	// tag and data
	// a write shows up at the read port the next cycle
	always_ff @(posedge clock) begin
		if (cache_fill.wr_en) begin
			tags[cache_fill.idx] <= cache_fill.tag;
			data[cache_fill.idx] <= cache_fill.data;
		end
	end

endmodule

`default_nettype wire

/* icache/icache_ctrl.sv */
// instruction cache miss controller that issues memory loads and writes the fills
`default_nettype none
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache_ctrl import fetch_pkg::*; (
	input  logic clock,
	input  logic rst,
	input  logic [`XLEN-1:0] lookup_pc,
	input  logic hit,
	input  mem_rsp_t mem_rsp,
	output mem_req_t mem_req,
	output cache_fill_t cache_fill
);

	// zero bits above the tag in a block address
	localparam int pad_bits = `XLEN - `TAG_BITS - `IDX_BITS - 3;

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait
	} state_e;

	state_e state;
	state_e state_next;

	// block being filled
	logic [`IDX_BITS-1:0] miss_idx;
	logic [`TAG_BITS-1:0] miss_tag;

	// tag memory gave the accepted load
	logic [`MEM_TAG_BITS-1:0] txn_tag;

	logic miss_seen;
	logic accepted;
	logic reply_match;

	////////////////////
	// handshake decode
	////////////////////

	// new miss only from idle, one outstanding at a time
	assign miss_seen = (state == st_idle) && !hit;

	// nonzero acceptance tag while presenting means taken
	assign accepted = (state == st_request) && (mem_rsp.response != '0);

	// our data is on the bus
	assign reply_match = (state == st_wait) && (mem_rsp.tag == txn_tag);

	////////////////////
	// fsm
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (miss_seen) begin
					state_next = st_request;
				end
			end
			st_request: begin
				// refused loads stay here and go out again
				if (accepted) begin
					state_next = st_wait;
				end
			end
			st_wait: begin
				// fill goes in even if fetch has moved on
				if (reply_match) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// miss block captured when seen
	always_ff @(posedge clock) begin
		if (miss_seen) begin
			miss_idx <= lookup_pc[`IDX_BITS+2:3];
			miss_tag <= lookup_pc[`TAG_BITS+`IDX_BITS+2:`IDX_BITS+3];
		end
	end

	// transaction tag captured on acceptance
	always_ff @(posedge clock) begin
		if (accepted) begin
			txn_tag <= mem_rsp.response;
		end
	end

	////////////////////
	// outputs
	////////////////////

	// load presented the cycle after the miss
	always_comb begin
		mem_req.cmd = (state == st_request) ? mem_load : mem_none;
		mem_req.addr = {{pad_bits{1'b0}}, miss_tag, miss_idx, 3'b000};
	end

	// written on the reply cycle, line hits the cycle after
	always_comb begin
		cache_fill.wr_en = reply_match;
		cache_fill.idx = miss_idx;
		cache_fill.tag = miss_tag;
		cache_fill.data = mem_rsp.data;
	end

	// a pending reply always has a real transaction tag to match
	a_wait_has_tag: assert property (
		@(posedge clock) disable iff (rst)
		(state == st_wait) |-> (txn_tag != '0)
	) else $error("icache_ctrl: waiting for a reply with a zero transaction tag");

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
// fetch stage holding the pc and consumer credits and forming two-slot fetch packets
`default_nettype none
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_stage import fetch_pkg::*; (
	input  logic clock,
	input  logic rst,
	input  logic redirect_valid,
	input  logic [`XLEN-1:0] redirect_pc,
	input  logic credit_return,
	output logic [`XLEN-1:0] lookup_pc,
	input  logic hit,
	input  cache_block_u hit_block,
	output fetch_packet_t fetch_out
);

	localparam logic [`CREDIT_BITS-1:0] credits_full = `CREDIT_BITS'(`FETCH_CREDITS);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pc_block;
	logic [`CREDIT_BITS-1:0] credits;

	logic fire;
	logic [1:0] slot_valid;

	// packet register
	logic [1:0] out_valid;
	logic [`XLEN-1:0] out_pc;
	cache_block_u out_block;

	assign pc_block = {pc[`XLEN-1:3], 3'b000};

	// hit with a credit in hand
	// a redirect kills the old-path packet before it is registered
	assign fire = hit && (credits != '0) && !redirect_valid;

	// entering at offset 4 drops slot 0
	assign slot_valid = pc[2] ? 2'b10 : 2'b11;

	////////////////////
	// pc
	////////////////////

	// redirect wins over sequential advance
	// zero credits or a miss holds the pc
	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
		end else if (redirect_valid) begin
			pc <= redirect_pc;
		end else if (fire) begin
			pc <= pc_block + `XLEN'(8);
		end
	end

	assign lookup_pc = pc;

	////////////////////
	// credits
	////////////////////

	// one out per packet, one back per return pulse
	always_ff @(posedge clock) begin
		if (rst) begin
			credits <= credits_full;
		end else begin
			case ({fire, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////
	// packet out
	////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			out_valid <= 2'b00;
		end else begin
			out_valid <= fire ? slot_valid : 2'b00;
		end
	end

	// payload only loads on a packet
	always_ff @(posedge clock) begin
		if (fire) begin
			out_pc <= pc_block;
			out_block <= hit_block;
		end
	end

	always_comb begin
		fetch_out.valid = out_valid;
		fetch_out.pc = out_pc;
		fetch_out.block = out_block;
	end

	// consumer never returns more credits than it was given
	a_credit_bounds: assert property (
		@(posedge clock) disable iff (rst)
		credits <= credits_full
	) else $error("fetch_stage: credit count out of range");

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
// fetch front end top tying the fetch stage to the instruction cache and memory bus
`default_nettype none
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top import fetch_pkg::*; (
	input  logic clock,
	input  logic rst,
	input  mem_rsp_t mem_rsp,
	output mem_req_t mem_req,
	input  logic redirect_valid,
	input  logic [`XLEN-1:0] redirect_pc,
	input  logic credit_return,
	output fetch_packet_t fetch_out
);

	// fetch stage to cache
	logic [`XLEN-1:0] lookup_pc;

	// cache read port back to fetch and controller
	logic hit;
	cache_block_u hit_block;

	// controller fill into the arrays
	cache_fill_t cache_fill;

	fetch_stage u_fetch_stage (
		.clock(clock),
		.rst(rst),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.credit_return(credit_return),
		.lookup_pc(lookup_pc),
		.hit(hit),
		.hit_block(hit_block),
		.fetch_out(fetch_out)
	);

	icache_ctrl u_icache_ctrl (
		.clock(clock),
		.rst(rst),
		.lookup_pc(lookup_pc),
		.hit(hit),
		.mem_rsp(mem_rsp),
		.mem_req(mem_req),
		.cache_fill(cache_fill)
	);

	icache_mem u_icache_mem (
		.clock(clock),
		.rst(rst),
		.lookup_pc(lookup_pc),
		.cache_fill(cache_fill),
		.hit(hit),
		.hit_block(hit_block)
	);

endmodule

`default_nettype wire

/* verif/mem_model.sv */
// tagged memory responder with fixed reply latency and random refusals
`default_nettype none
`timescale 1ns/1ps
`include "fetch_macros.svh"

module mem_model import fetch_pkg::*; #(
	parameter int latency = 6
) (
	input  logic clock,
	input  logic rst,
	input  mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	localparam logic [`XLEN-1:0] fill_key = 32'h1357_9bdf;

	integer seed;
	int cyc;
	logic [`MEM_TAG_BITS-1:0] next_tag;

	// load taken in the cycle now ending
	logic take_seen;
	logic [`MEM_TAG_BITS-1:0] take_tag;
	logic [`XLEN-1:0] take_addr;

	// replies in flight, oldest first
	int due_q[$];
	logic [`MEM_TAG_BITS-1:0] tag_q[$];
	logic [`XLEN-1:0] addr_q[$];

	// word at address w holds w xor key
	function automatic cache_block_u block_data(input logic [`XLEN-1:0] addr);
		cache_block_u blk;
		logic [`XLEN-1:0] w;
		w = {addr[`XLEN-1:3], 3'b000} >> 2;
		blk.inst[0] = w ^ fill_key;
		blk.inst[1] = (w + 1) ^ fill_key;
		return blk;
	endfunction

	initial begin
		seed = 32'hcf98_bd1a;
		cyc = 0;
		next_tag = `MEM_TAG_BITS'(1);
		take_seen = 1'b0;
		take_tag = '0;
		take_addr = '0;
		mem_rsp = '0;
	end

	// request and acceptance tag are settled mid cycle
	always @(negedge clock) begin
		take_seen = !rst && (mem_req.cmd == mem_load) && (mem_rsp.response != '0);
		take_tag = mem_rsp.response;
		take_addr = mem_req.addr;
	end

	always @(posedge clock) begin
		if (rst) begin
			cyc = 0;
			next_tag = `MEM_TAG_BITS'(1);
			due_q.delete();
			tag_q.delete();
			addr_q.delete();
			#1;
			mem_rsp = '0;
		end else begin
			cyc = cyc + 1;
			// load taken when our acceptance tag was nonzero
			if (take_seen) begin
				due_q.push_back(cyc + latency);
				tag_q.push_back(take_tag);
				addr_q.push_back({take_addr[`XLEN-1:3], 3'b000});
				// tags 1 to 15, zero means refused
				if (next_tag == '1) begin
					next_tag = `MEM_TAG_BITS'(1);
				end else begin
					next_tag = next_tag + `MEM_TAG_BITS'(1);
				end
			end
			#1;
			// about one cycle in four refuses
			if (($random(seed) & 3) == 0) begin
				mem_rsp.response = '0;
			end else begin
				mem_rsp.response = next_tag;
			end
			if ((due_q.size() > 0) && (due_q[0] == cyc + 1)) begin
				void'(due_q.pop_front());
				mem_rsp.tag = tag_q.pop_front();
				mem_rsp.data = block_data(addr_q.pop_front());
			end else begin
				mem_rsp.tag = '0;
				mem_rsp.data = '0;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/fetch_tb.sv */
// testbench for the fetch front end with a tagged memory model and a credit consumer
`default_nettype none
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb import fetch_pkg::*; ();

	localparam logic [`XLEN-1:0] fill_key = 32'h1357_9bdf;
	// 110 blocks over five tests
	// worst block is a retried miss plus a slow credit return, about 45 cycles
	localparam int max_cycles = 5000;

	logic clock;
	logic rst;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	logic redirect_valid;
	logic [`XLEN-1:0] redirect_pc;
	logic credit_return;
	fetch_packet_t fetch_out;

	// checker state
	logic [`XLEN-1:0] exp_pc;
	logic [`XLEN-1:0] old_block;
	logic redirect_pending;
	logic retry_due;
	logic [`XLEN-1:0] retry_addr;
	logic quiet_check;
	logic [`XLEN-1:0] quiet_block;
	mem_req_t exp_req;
	int pkt_count;
	int errors;
	int checks;
	int refusals;
	int accepts;
	int cyc;

	// consumer state
	integer seed;
	logic slow_return;
	logic pkt_seen;
	int delay;
	int outstanding;
	int max_outstanding;
	int return_q[$];

	// per test bookkeeping
	int first_err;
	int first_ref;
	int first_acc;

	fetch_top DUT (
		.clock(clock),
		.rst(rst),
		.mem_rsp(mem_rsp),
		.mem_req(mem_req),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.credit_return(credit_return),
		.fetch_out(fetch_out)
	);

	mem_model u_mem_model (
		.clock(clock),
		.rst(rst),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	////////////////////
	// reference
	////////////////////

	function automatic logic [`XLEN-1:0] block_of(input logic [`XLEN-1:0] pc);
		return {pc[`XLEN-1:3], 3'b000};
	endfunction

	// instruction at word address w is w xor key
	// entry at offset 4 keeps only slot 1
	function automatic fetch_packet_t expected_packet(input logic [`XLEN-1:0] pc);
		fetch_packet_t pkt;
		logic [`XLEN-1:0] w;
		w = block_of(pc) >> 2;
		pkt.valid = pc[2] ? 2'b10 : 2'b11;
		pkt.pc = block_of(pc);
		pkt.block.inst[0] = w ^ fill_key;
		pkt.block.inst[1] = (w + 1) ^ fill_key;
		return pkt;
	endfunction

	// payload only matters when a slot is valid
	task automatic compare_packet(input fetch_packet_t got, input fetch_packet_t exp,
			input string name);
		checks++;
		if ((got.valid !== exp.valid) || ((exp.valid != 2'b00) &&
				((got.pc !== exp.pc) || (got.block !== exp.block)))) begin
			errors++;
			$display("Fail %s valid exp 0x%0h got 0x%0h pc exp 0x%08h got 0x%08h",
				name, exp.valid, got.valid, exp.pc, got.pc);
			$display("Fail %s block exp 0x%016h got 0x%016h", name, exp.block, got.block);
		end
	endtask

	// address only matters on a load
	task automatic compare_req(input mem_req_t got, input mem_req_t exp, input string name);
		checks++;
		if ((got.cmd !== exp.cmd) || ((exp.cmd == mem_load) && (got.addr !== exp.addr))) begin
			errors++;
			$display("Fail %s cmd exp 0x%0h got 0x%0h addr exp 0x%08h got 0x%08h",
				name, exp.cmd, got.cmd, exp.addr, got.addr);
		end
	endtask

	task automatic wait_packets(input int n);
		while (pkt_count < n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// one cycle pulse
	task automatic redirect_to(input logic [`XLEN-1:0] pc);
		redirect_valid = 1'b1;
		redirect_pc = pc;
		@(posedge clock);
		#1;
		redirect_valid = 1'b0;
	endtask

	task automatic report_test(input int num, input string what);
		if (errors == first_err) begin
			$display("test %0d %s: ok", num, what);
		end else begin
			$display("test %0d %s: %0d errors", num, what, errors - first_err);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// cycle limit
	initial begin
		cyc = 0;
		while (cyc < max_cycles) begin
			@(posedge clock);
			cyc++;
		end
		$display("timeout after %0d cycles with %0d packets checked", cyc, pkt_count);
		$display("Test failed");
		$finish;
	end

	////////////////////
	// monitor
	////////////////////

	// outputs and inputs are settled mid cycle
	always @(negedge clock) begin
		if (!rst) begin
			if (mem_req.cmd == mem_load) begin
				// refused last cycle, same load again
				if (retry_due) begin
					exp_req.cmd = mem_load;
					exp_req.addr = retry_addr;
					compare_req(mem_req, exp_req, "mem_req retry");
				end
				if (quiet_check && (mem_req.addr != quiet_block)) begin
					errors++;
					$display("load for block 0x%08h while cached blocks streamed", mem_req.addr);
				end
				if (mem_rsp.response == '0) begin
					refusals++;
					retry_due = 1'b1;
					retry_addr = mem_req.addr;
				end else begin
					accepts++;
					retry_due = 1'b0;
					// a miss from before a redirect may still go out
					exp_req.cmd = mem_load;
					exp_req.addr = block_of(exp_pc);
					if (redirect_pending && (mem_req.addr == old_block)) begin
						exp_req.addr = old_block;
					end
					redirect_pending = 1'b0;
					compare_req(mem_req, exp_req, "mem_req load");
				end
			end else if (retry_due) begin
				errors++;
				retry_due = 1'b0;
				$display("refused load for block 0x%08h was not presented again", retry_addr);
			end
			// packets in order, no gaps
			if (fetch_out.valid != 2'b00) begin
				compare_packet(fetch_out, expected_packet(exp_pc), "fetch_out");
				exp_pc = block_of(exp_pc) + 8;
				pkt_count++;
			end
			// packets after this cycle belong to the new path
			if (redirect_valid) begin
				redirect_pending = 1'b1;
				old_block = block_of(exp_pc);
				exp_pc = redirect_pc;
			end
		end
	end

	////////////////////
	// consumer
	////////////////////

	initial begin
		credit_return = 1'b0;
		outstanding = 0;
		max_outstanding = 0;
		forever begin
			@(negedge clock);
			pkt_seen = !rst && (fetch_out.valid != 2'b00);
			@(posedge clock);
			#1;
			credit_return = 1'b0;
			if (pkt_seen) begin
				outstanding++;
				if (outstanding > max_outstanding) begin
					max_outstanding = outstanding;
				end
				if (outstanding > `FETCH_CREDITS) begin
					errors++;
					$display("%0d packets outstanding, more than the consumer holds", outstanding);
				end
				delay = $unsigned($random(seed)) % 6;
				if (slow_return) begin
					delay = delay + 10;
				end
				return_q.push_back(cyc + delay);
			end
			if ((return_q.size() > 0) && (return_q[0] <= cyc)) begin
				void'(return_q.pop_front());
				credit_return = 1'b1;
				outstanding--;
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////

	initial begin
		seed = 32'hcf98_bd1a;
		rst = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		slow_return = 1'b0;
		quiet_check = 1'b0;
		quiet_block = '0;
		exp_pc = '0;
		old_block = '0;
		redirect_pending = 1'b0;
		retry_due = 1'b0;
		retry_addr = '0;
		exp_req = '0;
		pkt_count = 0;
		errors = 0;
		checks = 0;
		refusals = 0;
		accepts = 0;
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;

		// reset state, then sequential from 0
		first_err = errors;
		compare_packet(fetch_out, '0, "fetch_out after reset");
		exp_req = '0;
		compare_req(mem_req, exp_req, "mem_req after reset");
		wait_packets(40);
		report_test(1, "reset state and 40 sequential blocks");

		// redirect into the middle of a block
		first_err = errors;
		redirect_to(32'h0000_2004);
		wait_packets(50);
		report_test(2, "redirect to offset 4");

		// cached lines 20 to 31 stream into slow credit returns
		first_err = errors;
		slow_return = 1'b1;
		max_outstanding = 0;
		redirect_to(32'h0000_00a0);
		wait_packets(70);
		slow_return = 1'b0;
		if (max_outstanding < `FETCH_CREDITS) begin
			errors++;
			$display("credits were never used up under back-pressure");
		end
		report_test(3, "back-pressure");

		// fresh region, every block misses
		first_err = errors;
		first_ref = refusals;
		first_acc = accepts;
		redirect_to(32'h0000_8000);
		wait_packets(94);
		if (refusals == first_ref) begin
			errors++;
			$display("no load was refused, retry path not exercised");
		end
		if (accepts - first_acc < 24) begin
			errors++;
			$display("fewer accepted loads than missing blocks");
		end
		report_test(4, "refused loads and miss addresses");

		// back to cached blocks, only the old path's load may still go out
		first_err = errors;
		quiet_block = block_of(exp_pc);
		quiet_check = 1'b1;
		redirect_to(32'h0000_8000);
		wait_packets(110);
		quiet_check = 1'b0;
		report_test(5, "refetch of cached blocks");

		$display("checks %0d, errors %0d, packets %0d, loads %0d, refusals %0d",
			checks, errors, pkt_count, accepts, refusals);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/fetch_pkg.sv
icache/icache_mem.sv
icache/icache_ctrl.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
verif/mem_model.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --Wno-fatal \
	-f project.f --top-module fetch_tb -o fetch_sim

# the simulation status itself is not trusted, the log decides
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
